// ==== rtl/bus_map_pkg.sv ====
package bus_map_pkg;

    // bus and storage widths
    localparam int bus_w         = 64;
    localparam int ram_word_w    = 32;
    localparam int sector_bytes  = 512;
    localparam int cache_index_w = $clog2(sector_bytes);
    localparam int fill_count_w  = $clog2(sector_bytes) + 1;

    // address map, one word per device register
    localparam logic [63:0] ram_base       = 64'h0000_0000_0000_1000;
    localparam logic [63:0] key_addr       = 64'h0000_0000_0000_8000;
    localparam logic [63:0] uart_addr      = 64'h0000_0000_0000_8008;
    localparam logic [63:0] sd_sector_addr = 64'h0000_0000_0000_8010;
    localparam logic [63:0] sd_read_addr   = 64'h0000_0000_0000_8018;
    localparam logic [63:0] sd_avail_addr  = 64'h0000_0000_0000_8020;
    localparam logic [63:0] sd_cache_base  = 64'h0000_0000_0000_9000;

    // access sizes, bit 2 flags an unsigned load
    localparam logic [2:0] size_byte   = 3'b000;
    localparam logic [2:0] size_half   = 3'b001;
    localparam logic [2:0] size_word   = 3'b010;
    localparam logic [2:0] size_double = 3'b011;

    // read source select
    localparam logic [1:0] src_ram   = 2'd0;
    localparam logic [1:0] src_cache = 2'd1;
    localparam logic [1:0] src_key   = 2'd2;
    localparam logic [1:0] src_avail = 2'd3;

    // capture kind for the read data register
    localparam logic [1:0] cap_none = 2'd0;
    localparam logic [1:0] cap_full = 2'd1;
    localparam logic [1:0] cap_low  = 2'd2;
    localparam logic [1:0] cap_high = 2'd3;

endpackage

// ==== rtl/bus_sequencer.sv ====
`timescale 1ns/1ps

module bus_sequencer #(
    parameter int ram_words = 1024
) (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  logic                          bus_read_enable,
    input  logic                          bus_write_enable,
    input  logic [2:0]                    bus_read_type,
    input  logic [2:0]                    bus_write_type,
    input  logic [bus_map_pkg::bus_w-1:0] bus_address,
    input  logic                          ram_sel,
    input  logic                          sd_cache_sel,
    input  logic                          key_sel,
    input  logic                          sd_avail_sel,
    output logic                          bus_done,
    output logic [$clog2(ram_words)-1:0]  ram_addr,
    output logic                          ram_we,
    output logic [3:0]                    ram_lanes,
    output logic                          ram_high_beat,
    output logic [1:0]                    read_src,
    output logic [1:0]                    data_capture,
    output logic [1:0]                    beat_count
);

    localparam int aw = $clog2(ram_words);

    typedef enum logic [2:0] {
        idle,
        write_high,
        read_wait,
        read_low,
        read_high
    } state_t;

    state_t        state;
    logic [aw-1:0] word_q;
    logic [aw-1:0] req_word;
    logic [2:0]    wr_size;
    logic [2:0]    rd_size;
    logic [3:0]    req_lanes;
    logic [1:0]    req_src;

    // unsigned flag does not matter here
    assign wr_size = {1'b0, bus_write_type[1:0]};
    assign rd_size = {1'b0, bus_read_type[1:0]};

    // word index inside the RAM window
    assign req_word = bus_address[aw+1:2] - bus_map_pkg::ram_base[aw+1:2];

    always_comb begin
        case (wr_size)
            bus_map_pkg::size_byte:   req_lanes = 4'b0001 << bus_address[1:0];
            bus_map_pkg::size_half:   req_lanes = 4'b0011 << {bus_address[1], 1'b0};
            bus_map_pkg::size_word:   req_lanes = 4'b1111;
            bus_map_pkg::size_double: req_lanes = 4'b1111;
            default:                  req_lanes = 4'b0000;
        endcase
    end

    always_comb begin
        if (sd_cache_sel) begin
            req_src = bus_map_pkg::src_cache;
        end else if (key_sel) begin
            req_src = bus_map_pkg::src_key;
        end else if (sd_avail_sel) begin
            req_src = bus_map_pkg::src_avail;
        end else begin
            req_src = bus_map_pkg::src_ram;
        end
    end

    // first beat goes straight from the request, second from the saved word
    assign ram_addr      = (state == idle) ? req_word : word_q + 1'b1;
    assign ram_we        = (state == idle && bus_write_enable && ram_sel) || state == write_high;
    assign ram_lanes     = (state == write_high) ? 4'b1111 : req_lanes;
    assign ram_high_beat = (state == write_high);
    assign bus_done      = (state == idle);

    always_comb begin
        case (state)
            read_wait: data_capture = bus_map_pkg::cap_full;
            read_low:  data_capture = bus_map_pkg::cap_low;
            read_high: data_capture = bus_map_pkg::cap_high;
            default:   data_capture = bus_map_pkg::cap_none;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= idle;
            word_q     <= '0;
            read_src   <= bus_map_pkg::src_ram;
            beat_count <= 2'd0;
        end else begin
            case (state)
                idle: begin
                    if (bus_write_enable) begin
                        word_q     <= req_word;
                        beat_count <= ram_sel ? 2'd1 : 2'd0;
                        if (ram_sel && wr_size == bus_map_pkg::size_double) begin
                            state <= write_high;
                        end
                    end else if (bus_read_enable) begin
                        word_q     <= req_word;
                        read_src   <= req_src;
                        beat_count <= ram_sel ? 2'd1 : 2'd0;
                        if (ram_sel && rd_size == bus_map_pkg::size_double) begin
                            state <= read_low;
                        end else begin
                            state <= read_wait;
                        end
                    end
                end
                write_high: begin
                    beat_count <= 2'd2;
                    state      <= idle;
                end
                read_low: begin
                    beat_count <= 2'd2;
                    state      <= read_high;
                end
                read_wait: state <= idle;
                read_high: state <= idle;
                default:   state <= idle;
            endcase
        end
    end

endmodule

// ==== rtl/sector_fill_counter.sv ====
`timescale 1ns/1ps

module sector_fill_counter (
    input  logic                                  CLOCK_50,
    input  logic                                  KEY0,
    input  logic                                  sd_byte_valid,
    input  logic                                  sd_rd_start,
    output logic [bus_map_pkg::cache_index_w-1:0] fill_index,
    output logic                                  fill_we,
    output logic                                  sd_avail
);

    logic [bus_map_pkg::fill_count_w-1:0] count;
    logic                                 not_full;

    assign not_full   = count < bus_map_pkg::sector_bytes;
    assign fill_we    = sd_byte_valid && not_full;
    assign fill_index = count[bus_map_pkg::cache_index_w-1:0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            count    <= '0;
            sd_avail <= 1'b0;
        end else if (sd_rd_start) begin
            // new sector request restarts the fill
            count    <= '0;
            sd_avail <= 1'b0;
        end else if (fill_we) begin
            count <= count + 1'b1;
            // last byte of the sector
            if (count == bus_map_pkg::sector_bytes - 1) begin
                sd_avail <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/word_ram.sv ====
`timescale 1ns/1ps

module word_ram #(
    parameter int ram_words = 1024
) (
    input  logic                               CLOCK_50,
    input  logic [$clog2(ram_words)-1:0]       ram_addr,
    input  logic                               ram_we,
    input  logic [3:0]                         ram_lanes,
    input  logic [bus_map_pkg::ram_word_w-1:0] ram_wdata,
    output logic [bus_map_pkg::ram_word_w-1:0] ram_rdata
);

    localparam int lanes = bus_map_pkg::ram_word_w / 8;

    logic [bus_map_pkg::ram_word_w-1:0] mem [ram_words];

    // byte lanes written independently, read is registered
    always_ff @(posedge CLOCK_50) begin
        if (ram_we) begin
            for (int lane = 0; lane < lanes; lane++) begin
                if (ram_lanes[lane]) begin
                    mem[ram_addr][lane*8 +: 8] <= ram_wdata[lane*8 +: 8];
                end
            end
        end
        ram_rdata <= mem[ram_addr];
    end

endmodule

// ==== rtl/sector_buffer.sv ====
`timescale 1ns/1ps

module sector_buffer (
    input  logic                                  CLOCK_50,
    input  logic                                  fill_we,
    input  logic [bus_map_pkg::cache_index_w-1:0] fill_index,
    input  logic [7:0]                            sd_byte,
    input  logic [bus_map_pkg::cache_index_w-1:0] cache_offset,
    output logic [7:0]                            cache_rdata
);

    logic [7:0] mem [bus_map_pkg::sector_bytes];

    // fill side from the SD byte stream
    always_ff @(posedge CLOCK_50) begin
        if (fill_we) begin
            mem[fill_index] <= sd_byte;
        end
    end

    // bus side
    always_ff @(posedge CLOCK_50) begin
        cache_rdata <= mem[cache_offset];
    end

endmodule

// ==== rtl/device_regs.sv ====
`timescale 1ns/1ps

module device_regs (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  logic                          bus_write_enable,
    input  logic                          uart_sel,
    input  logic                          sd_sector_sel,
    input  logic                          sd_read_sel,
    input  logic [bus_map_pkg::bus_w-1:0] bus_write_data,
    input  logic [7:0]                    key_ascii,
    input  logic                          key_pressed,
    input  logic                          irq_ack,
    output logic [31:0]                   sd_sector,
    output logic                          sd_rd_start,
    output logic                          uart_valid,
    output logic [7:0]                    uart_data,
    output logic [3:0]                    irq_vector,
    output logic [7:0]                    key_data
);

    logic key_event;

    assign key_event = key_pressed && (key_ascii != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_sector   <= 32'd0;
            sd_rd_start <= 1'b0;
            uart_valid  <= 1'b0;
            irq_vector  <= 4'd0;
            key_data    <= 8'd0;
        end else begin
            sd_rd_start <= bus_write_enable && sd_read_sel;
            uart_valid  <= bus_write_enable && uart_sel;
            if (bus_write_enable && sd_sector_sel) begin
                sd_sector <= bus_write_data[31:0];
            end
            if (key_event) begin
                key_data   <= key_ascii;
                irq_vector <= 4'd1;
            end
            // ack wins over a key in the same cycle
            if (irq_vector != 4'd0 && irq_ack) begin
                irq_vector <= 4'd0;
            end
        end
    end

    // character byte for the UART strobe
    always_ff @(posedge CLOCK_50) begin
        if (bus_write_enable && uart_sel) begin
            uart_data <= bus_write_data[7:0];
        end
    end

endmodule

// ==== rtl/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int ram_words = 1024
) (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  logic [bus_map_pkg::bus_w-1:0] bus_address,
    input  logic [bus_map_pkg::bus_w-1:0] bus_write_data,
    input  logic                          bus_write_enable,
    input  logic                          bus_read_enable,
    input  logic [2:0]                    bus_read_type,
    input  logic [2:0]                    bus_write_type,
    input  logic [7:0]                    sd_byte,
    input  logic                          sd_byte_valid,
    input  logic [7:0]                    key_ascii,
    input  logic                          key_pressed,
    input  logic                          irq_ack,
    output logic [bus_map_pkg::bus_w-1:0] bus_read_data,
    output logic                          bus_done,
    output logic [31:0]                   sd_sector,
    output logic                          sd_rd_start,
    output logic                          uart_valid,
    output logic [7:0]                    uart_data,
    output logic [3:0]                    irq_vector
);

    localparam int aw = $clog2(ram_words);

    logic                                  ram_sel;
    logic                                  key_sel;
    logic                                  uart_sel;
    logic                                  sd_sector_sel;
    logic                                  sd_read_sel;
    logic                                  sd_avail_sel;
    logic                                  sd_cache_sel;
    logic [aw-1:0]                         ram_addr;
    logic                                  ram_we;
    logic [3:0]                            ram_lanes;
    logic                                  ram_high_beat;
    logic [bus_map_pkg::ram_word_w-1:0]    ram_wdata;
    logic [bus_map_pkg::ram_word_w-1:0]    ram_rdata;
    logic [1:0]                            read_src;
    logic [1:0]                            data_capture;
    logic [bus_map_pkg::cache_index_w-1:0] fill_index;
    logic                                  fill_we;
    logic                                  sd_avail;
    logic [bus_map_pkg::cache_index_w-1:0] cache_offset;
    logic [7:0]                            cache_rdata;
    logic [7:0]                            key_data;
    logic [bus_map_pkg::bus_w-1:0]         src_word;

    // address decoder
    assign ram_sel = bus_address >= bus_map_pkg::ram_base &&
                     bus_address < bus_map_pkg::ram_base + 64'(4 * ram_words);
    assign sd_cache_sel = bus_address >= bus_map_pkg::sd_cache_base &&
                          bus_address < bus_map_pkg::sd_cache_base +
                                        64'(bus_map_pkg::sector_bytes);
    assign key_sel       = bus_address == bus_map_pkg::key_addr;
    assign uart_sel      = bus_address == bus_map_pkg::uart_addr;
    assign sd_sector_sel = bus_address == bus_map_pkg::sd_sector_addr;
    assign sd_read_sel   = bus_address == bus_map_pkg::sd_read_addr;
    assign sd_avail_sel  = bus_address == bus_map_pkg::sd_avail_addr;

    assign cache_offset = bus_address[bus_map_pkg::cache_index_w-1:0] -
                          bus_map_pkg::sd_cache_base[bus_map_pkg::cache_index_w-1:0];

    // narrow stores copied onto every lane, the mask picks the right one
    always_comb begin
        case ({1'b0, bus_write_type[1:0]})
            bus_map_pkg::size_byte: ram_wdata = {4{bus_write_data[7:0]}};
            bus_map_pkg::size_half: ram_wdata = {2{bus_write_data[15:0]}};
            default: ram_wdata = ram_high_beat ? bus_write_data[63:32] : bus_write_data[31:0];
        endcase
    end

    // read mux, RAM word shifted down to the addressed byte
    always_comb begin
        case (read_src)
            bus_map_pkg::src_ram:   src_word = {32'd0, ram_rdata >> {bus_address[1:0], 3'b000}};
            bus_map_pkg::src_cache: src_word = {56'd0, cache_rdata};
            bus_map_pkg::src_key:   src_word = {56'd0, key_data};
            default:                src_word = {63'd0, sd_avail};
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        case (data_capture)
            bus_map_pkg::cap_full: bus_read_data <= src_word;
            bus_map_pkg::cap_low:  bus_read_data <= {32'd0, ram_rdata};
            bus_map_pkg::cap_high: bus_read_data[63:32] <= ram_rdata;
            default:               bus_read_data <= bus_read_data;
        endcase
    end

    bus_sequencer #(
        .ram_words(ram_words)
    ) i_bus_sequencer (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_read_enable (bus_read_enable),
        .bus_write_enable(bus_write_enable),
        .bus_read_type   (bus_read_type),
        .bus_write_type  (bus_write_type),
        .bus_address     (bus_address),
        .ram_sel         (ram_sel),
        .sd_cache_sel    (sd_cache_sel),
        .key_sel         (key_sel),
        .sd_avail_sel    (sd_avail_sel),
        .bus_done        (bus_done),
        .ram_addr        (ram_addr),
        .ram_we          (ram_we),
        .ram_lanes       (ram_lanes),
        .ram_high_beat   (ram_high_beat),
        .read_src        (read_src),
        .data_capture    (data_capture),
        .beat_count      ()
    );

    word_ram #(
        .ram_words(ram_words)
    ) i_word_ram (
        .CLOCK_50 (CLOCK_50),
        .ram_addr (ram_addr),
        .ram_we   (ram_we),
        .ram_lanes(ram_lanes),
        .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata)
    );

    sector_fill_counter i_sector_fill_counter (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .sd_byte_valid(sd_byte_valid),
        .sd_rd_start  (sd_rd_start),
        .fill_index   (fill_index),
        .fill_we      (fill_we),
        .sd_avail     (sd_avail)
    );

    sector_buffer i_sector_buffer (
        .CLOCK_50    (CLOCK_50),
        .fill_we     (fill_we),
        .fill_index  (fill_index),
        .sd_byte     (sd_byte),
        .cache_offset(cache_offset),
        .cache_rdata (cache_rdata)
    );

    device_regs i_device_regs (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_write_enable(bus_write_enable),
        .uart_sel        (uart_sel),
        .sd_sector_sel   (sd_sector_sel),
        .sd_read_sel     (sd_read_sel),
        .bus_write_data  (bus_write_data),
        .key_ascii       (key_ascii),
        .key_pressed     (key_pressed),
        .irq_ack         (irq_ack),
        .sd_sector       (sd_sector),
        .sd_rd_start     (sd_rd_start),
        .uart_valid      (uart_valid),
        .uart_data       (uart_data),
        .irq_vector      (irq_vector),
        .key_data        (key_data)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 50,
    parameter int reset_cycles = 16
) (
    output logic CLOCK_50,
    output logic KEY0
);

    initial begin
        CLOCK_50 = 1'b0;
        forever #half_period CLOCK_50 = ~CLOCK_50;
    end

    // reset let go on a falling edge
    initial begin
        KEY0 = 1'b0;
        repeat (reset_cycles) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
    end

endmodule

// ==== verification/soc_bus_props.sv ====
`timescale 1ns/1ps

module soc_bus_props (
    input logic       CLOCK_50,
    input logic       KEY0,
    input logic       bus_read_enable,
    input logic       bus_write_enable,
    input logic       bus_done,
    input logic       uart_valid,
    input logic       irq_ack,
    input logic [3:0] irq_vector
);

    int fail_count = 0;

    // fabric idle as soon as reset lets go
    done_after_reset: assert property (@(posedge CLOCK_50) $rose(KEY0) |-> bus_done)
        else begin
            fail_count++;
            $error("bus_done is low right after reset");
        end

    // requests only while the fabric is idle
    request_when_done: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) |-> bus_done)
        else begin
            fail_count++;
            $error("bus request arrived while bus_done was low");
        end

    uart_single_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_valid |=> !uart_valid)
        else begin
            fail_count++;
            $error("uart_valid stayed high for more than one cycle");
        end

    irq_cleared_by_ack: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (irq_ack && irq_vector != 4'd0) |=> (irq_vector == 4'd0))
        else begin
            fail_count++;
            $error("irq_vector not cleared the cycle after irq_ack");
        end

endmodule

bind soc_bus_top soc_bus_props i_soc_bus_props (
    .CLOCK_50        (CLOCK_50),
    .KEY0            (KEY0),
    .bus_read_enable (bus_read_enable),
    .bus_write_enable(bus_write_enable),
    .bus_done        (bus_done),
    .uart_valid      (uart_valid),
    .irq_ack         (irq_ack),
    .irq_vector      (irq_vector)
);

// ==== verification/tb_soc_bus.sv ====
`timescale 1ns/1ps

module tb_soc_bus;

    localparam int ram_words  = 1024;
    localparam int done_limit = 20;
    localparam int reset_limit = 40;

    logic        CLOCK_50;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [2:0]  bus_read_type;
    logic [2:0]  bus_write_type;
    logic [7:0]  sd_byte;
    logic        sd_byte_valid;
    logic [7:0]  key_ascii;
    logic        key_pressed;
    logic        irq_ack;
    logic [63:0] bus_read_data;
    logic        bus_done;
    logic [31:0] sd_sector;
    logic        sd_rd_start;
    logic        uart_valid;
    logic [7:0]  uart_data;
    logic [3:0]  irq_vector;

    logic [15:0] lfsr_state = 16'd46285;
    // byte images of the first 16 RAM words and of the sector
    logic [7:0]  ram_model [64];
    logic [7:0]  sector_model [bus_map_pkg::sector_bytes];
    int          check_count = 0;
    int          error_count = 0;

    tb_clock i_tb_clock (
        .CLOCK_50(CLOCK_50),
        .KEY0    (KEY0)
    );

    soc_bus_top #(
        .ram_words(ram_words)
    ) i_soc_bus_top (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_address     (bus_address),
        .bus_write_data  (bus_write_data),
        .bus_write_enable(bus_write_enable),
        .bus_read_enable (bus_read_enable),
        .bus_read_type   (bus_read_type),
        .bus_write_type  (bus_write_type),
        .sd_byte         (sd_byte),
        .sd_byte_valid   (sd_byte_valid),
        .key_ascii       (key_ascii),
        .key_pressed     (key_pressed),
        .irq_ack         (irq_ack),
        .bus_read_data   (bus_read_data),
        .bus_done        (bus_done),
        .sd_sector       (sd_sector),
        .sd_rd_start     (sd_rd_start),
        .uart_valid      (uart_valid),
        .uart_data       (uart_data),
        .irq_vector      (irq_vector)
    );

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // little endian word from the byte image
    function automatic logic [31:0] model_word(input int w);
        return {ram_model[4*w+3], ram_model[4*w+2], ram_model[4*w+1], ram_model[4*w]};
    endfunction

    task automatic model_store(input int offset, input logic [63:0] data, input int nbytes);
        for (int i = 0; i < nbytes; i++) begin
            ram_model[offset+i] = data[8*i +: 8];
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("Mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_run;
        int prop_fails;
        prop_fails = i_soc_bus_top.i_soc_bus_props.fail_count;
        $display("checks %0d, check errors %0d, property failures %0d",
                 check_count, error_count, prop_fails);
        if (error_count == 0 && prop_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic wait_reset;
        int cycles;
        cycles = 0;
        while (KEY0 !== 1'b1 && cycles < reset_limit) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        if (KEY0 !== 1'b1) begin
            error_count++;
            $display("Timeout: reset was never released");
        end
    endtask

    task automatic wait_done(input string what);
        int cycles;
        cycles = 0;
        while (!bus_done && cycles < done_limit) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        if (!bus_done) begin
            error_count++;
            $display("Timeout: bus_done stayed low after %s", what);
        end
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [2:0] size);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_type   = size;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        wait_done("a write");
    endtask

    task automatic bus_read(input logic [63:0] addr, input logic [2:0] size,
                            output logic [63:0] rd);
        bus_address     = addr;
        bus_read_type   = size;
        bus_read_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        wait_done("a read");
        rd = bus_read_data;
    endtask

    // one random sector into the SD stream, then one extra byte
    task automatic stream_sector;
        for (int i = 0; i < bus_map_pkg::sector_bytes; i++) begin
            sector_model[i] = 8'(rand_bits(8));
            sd_byte         = sector_model[i];
            sd_byte_valid   = 1'b1;
            @(negedge CLOCK_50);
        end
        // one byte past a full sector is dropped
        sd_byte = ~sector_model[0];
        @(negedge CLOCK_50);
        sd_byte_valid = 1'b0;
    endtask

    initial begin
        logic [63:0] data;
        logic [63:0] rd;
        logic [63:0] base;
        logic [7:0]  ascii;
        int          w;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        bus_read_type    = bus_map_pkg::size_word;
        bus_write_type   = bus_map_pkg::size_word;
        sd_byte          = 8'd0;
        sd_byte_valid    = 1'b0;
        key_ascii        = 8'd0;
        key_pressed      = 1'b0;
        irq_ack          = 1'b0;
        base             = bus_map_pkg::ram_base;

        wait_reset;
        check_value("bus_done", 64'(bus_done), 64'd1);

        // full words over the first 16 RAM words
        for (int i = 0; i < 16; i++) begin
            data = rand_bits(32);
            bus_write(base + 64'(4 * i), data, bus_map_pkg::size_word);
            model_store(4 * i, data, 4);
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(base + 64'(4 * i), bus_map_pkg::size_word, rd);
            check_value("bus_read_data", rd, {32'd0, model_word(i)});
        end

        // byte stores into word 4, unsigned byte loads
        for (int k = 0; k < 4; k++) begin
            data = rand_bits(8);
            bus_write(base + 64'(16 + k), data, bus_map_pkg::size_byte);
            model_store(16 + k, data, 1);
            bus_read(base + 64'(16 + k), 3'b100 | bus_map_pkg::size_byte, rd);
            check_value("bus_read_data", rd, {32'd0, model_word(4) >> (8 * k)});
        end

        // half stores into word 5, then half loads at every offset
        for (int k = 0; k < 4; k += 2) begin
            data = rand_bits(16);
            bus_write(base + 64'(20 + k), data, bus_map_pkg::size_half);
            model_store(20 + k, data, 2);
        end
        for (int k = 0; k < 4; k++) begin
            bus_read(base + 64'(20 + k), bus_map_pkg::size_half, rd);
            check_value("bus_read_data", rd, {32'd0, model_word(5) >> (8 * k)});
        end

        // doublewords, last one straddles an odd word
        for (int i = 0; i < 3; i++) begin
            w = (i == 2) ? 13 : 8 + 2 * i;
            data = rand_bits(64);
            bus_write(base + 64'(4 * w), data, bus_map_pkg::size_double);
            model_store(4 * w, data, 8);
            bus_read(base + 64'(4 * w), bus_map_pkg::size_double, rd);
            check_value("bus_read_data", rd, {model_word(w + 1), model_word(w)});
            bus_read(base + 64'(4 * w + 4), bus_map_pkg::size_word, rd);
            check_value("bus_read_data", rd, {32'd0, model_word(w + 1)});
        end

        // neighbours must be untouched
        for (int i = 0; i < 16; i++) begin
            bus_read(base + 64'(4 * i), bus_map_pkg::size_word, rd);
            check_value("bus_read_data", rd, {32'd0, model_word(i)});
        end

        // SD sector number
        data = rand_bits(32);
        bus_write(bus_map_pkg::sd_sector_addr, data, bus_map_pkg::size_word);
        check_value("sd_sector", 64'(sd_sector), data);

        // fill once so the trigger has a flag and a count to clear
        stream_sector;
        bus_read(bus_map_pkg::sd_avail_addr, bus_map_pkg::size_word, rd);
        check_value("bus_read_data", rd, 64'd1);

        bus_write(bus_map_pkg::sd_read_addr, 64'd1, bus_map_pkg::size_word);
        check_value("sd_rd_start", 64'(sd_rd_start), 64'd1);
        @(negedge CLOCK_50);
        check_value("sd_rd_start", 64'(sd_rd_start), 64'd0);
        bus_read(bus_map_pkg::sd_avail_addr, bus_map_pkg::size_word, rd);
        check_value("bus_read_data", rd, 64'd0);

        stream_sector;
        bus_read(bus_map_pkg::sd_avail_addr, bus_map_pkg::size_word, rd);
        check_value("bus_read_data", rd, 64'd1);
        for (int i = 0; i < bus_map_pkg::sector_bytes; i++) begin
            bus_read(bus_map_pkg::sd_cache_base + 64'(i), bus_map_pkg::size_byte, rd);
            check_value("bus_read_data", rd, {56'd0, sector_model[i]});
        end

        // keyboard interrupt and ack
        ascii       = 8'(rand_bits(7)) | 8'h01;
        key_ascii   = ascii;
        key_pressed = 1'b1;
        @(negedge CLOCK_50);
        key_pressed = 1'b0;
        check_value("irq_vector", 64'(irq_vector), 64'd1);
        bus_read(bus_map_pkg::key_addr, bus_map_pkg::size_byte, rd);
        check_value("bus_read_data", rd, {56'd0, ascii});
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        check_value("irq_vector", 64'(irq_vector), 64'd0);

        // UART character strobe
        data = rand_bits(64);
        bus_write(bus_map_pkg::uart_addr, data, bus_map_pkg::size_byte);
        check_value("uart_valid", 64'(uart_valid), 64'd1);
        check_value("uart_data", 64'(uart_data), 64'(data[7:0]));
        @(negedge CLOCK_50);
        check_value("uart_valid", 64'(uart_valid), 64'd0);

        end_run;
    end

endmodule

// ==== filelist.f ====
rtl/bus_map_pkg.sv
rtl/bus_sequencer.sv
rtl/sector_fill_counter.sv
rtl/word_ram.sv
rtl/sector_buffer.sv
rtl/device_regs.sv
rtl/soc_bus_top.sv
verification/tb_clock.sv
verification/soc_bus_props.sv
verification/tb_soc_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bus fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_soc_bus +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0
